//--- sparse_sel_top.f
+incdir+hdl
hdl/sparse_chunk_pkg.sv
hdl/sparse_ctrl_pkg.sv
hdl/data_chunk_buffer.sv
hdl/match_priority_encoder.sv
hdl/input_selector.sv
hdl/sparse_sel_top.sv
verification/sparse_sel_checker.sv
verification/sparse_sel_tb.sv

//--- verification/sparse_sel_testdata.txt
// ifm_map fil_map last_seg wr_bank rd_bank, maps are 32-bit hex
// bit 8*s+i of a map is element i of segment s
FFFFFFFF FFFFFFFF 3 0 0
FFFFFFFF FFFFFFFF 3 1 1
A5A5A5A5 5AFF0F3C 3 0 0
12345678 0F0F0F0F 3 1 0
00FF00FF FF00FF00 3 0 1
FF00FF0F 0F00F0FF 3 1 0
FF00FF0F 0F00F0FF 3 0 0
00000000 00000000 3 1 1
00000000 00000000 0 0 0
80000001 80000001 0 1 1
80000001 80000001 3 0 0
F0F0F0F0 FFFFFFFF 1 1 1
0000FF00 0000FF00 0 0 0
0000FF00 0000FF00 1 1 1
C3000000 81000000 3 0 0
00000080 00000080 2 1 1
DEADBEEF CAFEF00D 3 0 0
13579BDF 2468ACE0 2 1 1
7FFFFFFE 7FFFFFFE 3 0 0
FEDCBA98 76543210 3 1 0
55555555 AAAAAAAA 3 0 1
FFFFFFFF 01020408 3 1 0

//--- verification/sparse_sel_tb.sv
`timescale 1ns/1ns
`include "sparse_sel_cfg.svh"

module sparse_sel_tb;

	localparam int NUM_TESTS   = 22;
	localparam int CHUNK_BITS  = `BUS_SIZE * `SEG_NUM;
	localparam int CYCLE_LIMIT = NUM_TESTS * 64 + 100;

	logic                                gated_clk_0_w;
	logic                                rst_i;
	logic                                ifm_wr_valid_i;
	logic                                ifm_wr_sel_i;
	logic [$clog2(`SEG_NUM)-1:0]         ifm_wr_count_i;
	logic [`BUS_SIZE-1:0]                ifm_wr_sparsemap_i;
	logic [`BUS_SIZE-1:0][`ELEM_W-1:0]   ifm_wr_nonzero_data_i;
	logic                                fil_wr_valid_i;
	logic                                fil_wr_sel_i;
	logic [$clog2(`SEG_NUM)-1:0]         fil_wr_count_i;
	logic [`BUS_SIZE-1:0]                fil_wr_sparsemap_i;
	logic [`BUS_SIZE-1:0][`ELEM_W-1:0]   fil_wr_nonzero_data_i;
	logic                                ifm_rd_sel_i;
	logic                                fil_rd_sel_i;
	logic                                sub_chunk_start_i;
	logic [$clog2(`SEG_NUM)-1:0]         last_seg_i;
	logic [`ELEM_W-1:0]                  ifm_data_o;
	logic signed [`ELEM_W-1:0]           fil_data_o;
	logic                                data_valid_o;
	logic                                sub_chunk_end_o;

	// Five words per test line
	logic [31:0]           test_mem [0:NUM_TESTS*5-1];

	// Reference copy of both banks, bytes kept by element position
	logic [CHUNK_BITS-1:0] ifm_map_bank [`BANK_NUM];
	logic [CHUNK_BITS-1:0] fil_map_bank [`BANK_NUM];
	logic [`ELEM_W-1:0]    ifm_byte_bank [`BANK_NUM][CHUNK_BITS];
	logic [`ELEM_W-1:0]    fil_byte_bank [`BANK_NUM][CHUNK_BITS];

	logic [31:0]           rand_state;
	int                    cycle_cnt  = 0;

	sparse_sel_top UUT (.*);

	sparse_sel_checker u_checker (
		 .gated_clk_0_w
		,.rst_i
		,.ifm_data_i(ifm_data_o)
		,.fil_data_i(fil_data_o)
		,.data_valid_i(data_valid_o)
		,.sub_chunk_end_i(sub_chunk_end_o)
	);

	initial gated_clk_0_w = 1'b0;
	always #4 gated_clk_0_w = ~gated_clk_0_w;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_byte(output logic [`ELEM_W-1:0] b);
		rand_state = xorshift32(rand_state);
		b = rand_state[`ELEM_W-1:0];
		if (b == '0) begin
			b = 1;
		end
	endtask

	task automatic report_counts();
		$display("errors: mismatch=%0d protocol=%0d",
			u_checker.mismatch_count, u_checker.protocol_count);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Chunk write and sub-chunk run
	//////////////////////////////////////////////////////////////////////

	task automatic write_chunks(input logic [31:0] ifm_map, input logic [31:0] fil_map,
		input logic bank);
		logic [`BUS_SIZE-1:0][`ELEM_W-1:0] ifm_row;
		logic [`BUS_SIZE-1:0][`ELEM_W-1:0] fil_row;
		logic [`ELEM_W-1:0]                b;
		int                                k_ifm;
		int                                k_fil;
		int                                pos;
		for (int s = 0; s < `SEG_NUM; s++) begin
			// Tail bytes past the popcount are don't-care
			ifm_row = {`BUS_SIZE{8'hEE}};
			fil_row = {`BUS_SIZE{8'hEE}};
			k_ifm = 0;
			k_fil = 0;
			for (int i = 0; i < `BUS_SIZE; i++) begin
				pos = s * `BUS_SIZE + i;
				if (ifm_map[pos]) begin
					next_byte(b);
					ifm_byte_bank[bank][pos] = b;
					ifm_row[k_ifm] = b;
					k_ifm++;
				end
				if (fil_map[pos]) begin
					next_byte(b);
					fil_byte_bank[bank][pos] = b;
					fil_row[k_fil] = b;
					k_fil++;
				end
			end
			@(posedge gated_clk_0_w);
			ifm_wr_valid_i        <= 1'b1;
			ifm_wr_sel_i          <= bank;
			ifm_wr_count_i        <= sparse_ctrl_pkg::seg_addr_t'(s);
			ifm_wr_sparsemap_i    <= ifm_map[s*`BUS_SIZE +: `BUS_SIZE];
			ifm_wr_nonzero_data_i <= ifm_row;
			fil_wr_valid_i        <= 1'b1;
			fil_wr_sel_i          <= bank;
			fil_wr_count_i        <= sparse_ctrl_pkg::seg_addr_t'(s);
			fil_wr_sparsemap_i    <= fil_map[s*`BUS_SIZE +: `BUS_SIZE];
			fil_wr_nonzero_data_i <= fil_row;
		end
		ifm_map_bank[bank] = ifm_map;
		fil_map_bank[bank] = fil_map;
	endtask

	// Common bits of segments 0 to last_seg, lowest first
	task automatic queue_expected(input logic [1:0] last_seg, input logic bank);
		int seg_limit;
		seg_limit = (int'(last_seg) + 1) * `BUS_SIZE;
		for (int pos = 0; pos < seg_limit; pos++) begin
			if (ifm_map_bank[bank][pos] && fil_map_bank[bank][pos]) begin
				u_checker.expect_pair(ifm_byte_bank[bank][pos], fil_byte_bank[bank][pos]);
			end
		end
		u_checker.expect_end();
	endtask

	task automatic run_sub_chunk(input logic [1:0] last_seg, input logic bank);
		@(posedge gated_clk_0_w);
		ifm_wr_valid_i    <= 1'b0;
		fil_wr_valid_i    <= 1'b0;
		ifm_rd_sel_i      <= bank;
		fil_rd_sel_i      <= bank;
		last_seg_i        <= last_seg;
		sub_chunk_start_i <= 1'b1;
		@(posedge gated_clk_0_w);
		sub_chunk_start_i <= 1'b0;
		do begin
			@(posedge gated_clk_0_w);
		end while (!sub_chunk_end_o);
	endtask

	initial begin : main_sequence
		logic [31:0] ifm_map;
		logic [31:0] fil_map;
		logic [1:0]  last_seg;
		logic        wr_bank;
		logic        rd_bank;
		rst_i                 = 1'b1;
		ifm_wr_valid_i        = 1'b0;
		ifm_wr_sel_i          = 1'b0;
		ifm_wr_count_i        = '0;
		ifm_wr_sparsemap_i    = '0;
		ifm_wr_nonzero_data_i = '0;
		fil_wr_valid_i        = 1'b0;
		fil_wr_sel_i          = 1'b0;
		fil_wr_count_i        = '0;
		fil_wr_sparsemap_i    = '0;
		fil_wr_nonzero_data_i = '0;
		ifm_rd_sel_i          = 1'b0;
		fil_rd_sel_i          = 1'b0;
		sub_chunk_start_i     = 1'b0;
		last_seg_i            = '0;
		rand_state            = 32'd12613;
		$readmemh("verification/sparse_sel_testdata.txt", test_mem);

		repeat (2) @(posedge gated_clk_0_w);
		rst_i <= 1'b0;
		// Quiet period, no output may appear before a start
		repeat (6) @(posedge gated_clk_0_w);

		for (int t = 0; t < NUM_TESTS; t++) begin
			ifm_map  = test_mem[t*5];
			fil_map  = test_mem[t*5+1];
			last_seg = test_mem[t*5+2][1:0];
			wr_bank  = test_mem[t*5+3][0];
			rd_bank  = test_mem[t*5+4][0];
			write_chunks(ifm_map, fil_map, wr_bank);
			queue_expected(last_seg, rd_bank);
			run_sub_chunk(last_seg, rd_bank);
		end

		// Trailing cycles catch stray outputs after the last run
		repeat (4) @(posedge gated_clk_0_w);
		report_counts();
		if (u_checker.mismatch_count + u_checker.protocol_count == 0) begin
			$display("All tests passed!");
		end
		else begin
			$display("Test failures found");
		end
		$finish;
	end

	always @(posedge gated_clk_0_w) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("ERROR: timeout after %0d cycles waiting for sub_chunk_end_o", cycle_cnt);
			report_counts();
			$display("Test failures found");
			$finish;
		end
	end

endmodule

//--- verification/sparse_sel_checker.sv
`timescale 1ns/1ns
`include "sparse_sel_cfg.svh"

module sparse_sel_checker (
	 input  logic                  gated_clk_0_w
	,input  logic                  rst_i
	,input  logic [`ELEM_W-1:0]    ifm_data_i
	,input  logic [`ELEM_W-1:0]    fil_data_i
	,input  logic                  data_valid_i
	,input  logic                  sub_chunk_end_i
);

	// Expected pairs in output order
	logic [`ELEM_W-1:0] exp_ifm_q [$];
	logic [`ELEM_W-1:0] exp_fil_q [$];
	int                 pending_ends   = 0;
	int                 mismatch_count = 0;
	int                 protocol_count = 0;

	task automatic expect_pair(input logic [`ELEM_W-1:0] ifm_b, input logic [`ELEM_W-1:0] fil_b);
		exp_ifm_q.push_back(ifm_b);
		exp_fil_q.push_back(fil_b);
	endtask

	task automatic expect_end();
		pending_ends++;
	endtask

	// Sampled mid-cycle, outputs are stable here
	always @(negedge gated_clk_0_w) begin : check_outputs
		logic [`ELEM_W-1:0] exp_ifm;
		logic [`ELEM_W-1:0] exp_fil;
		if (!rst_i) begin
			if (data_valid_i) begin
				if (exp_ifm_q.size() == 0) begin
					$display("ERROR: data_valid_o high with no pair expected at %0t", $time);
					protocol_count++;
				end
				else begin
					exp_ifm = exp_ifm_q.pop_front();
					exp_fil = exp_fil_q.pop_front();
					if (ifm_data_i !== exp_ifm) begin
						$display("MISMATCH ifm_data_o: got %h expected %h", ifm_data_i, exp_ifm);
						mismatch_count++;
					end
					if (fil_data_i !== exp_fil) begin
						$display("MISMATCH fil_data_o: got %h expected %h", fil_data_i, exp_fil);
						mismatch_count++;
					end
				end
			end
			// Final pair and end pulse share a cycle
			if (sub_chunk_end_i) begin
				if (pending_ends == 0) begin
					$display("ERROR: sub_chunk_end_o pulsed with no run pending at %0t", $time);
					protocol_count++;
				end
				else if (exp_ifm_q.size() != 0) begin
					$display("ERROR: sub_chunk_end_o came early, %0d pairs still missing",
						exp_ifm_q.size());
					protocol_count++;
					pending_ends--;
					exp_ifm_q.delete();
					exp_fil_q.delete();
				end
				else begin
					pending_ends--;
				end
			end
		end
	end

endmodule

//--- hdl/sparse_sel_top.sv
`timescale 1ns/1ns
`include "sparse_sel_cfg.svh"

module sparse_sel_top (
	 input  logic                                        gated_clk_0_w
	,input  logic                                        rst_i

	// IFM chunk write
	,input  logic                                        ifm_wr_valid_i
	,input  logic                                        ifm_wr_sel_i
	,input  sparse_ctrl_pkg::seg_addr_t                  ifm_wr_count_i
	,input  sparse_chunk_pkg::seg_map_t                  ifm_wr_sparsemap_i
	,input  sparse_chunk_pkg::act_t [`BUS_SIZE-1:0]      ifm_wr_nonzero_data_i

	// Filter chunk write
	,input  logic                                        fil_wr_valid_i
	,input  logic                                        fil_wr_sel_i
	,input  sparse_ctrl_pkg::seg_addr_t                  fil_wr_count_i
	,input  sparse_chunk_pkg::seg_map_t                  fil_wr_sparsemap_i
	,input  sparse_chunk_pkg::wgt_t [`BUS_SIZE-1:0]      fil_wr_nonzero_data_i

	// Sub-chunk run
	,input  logic                                        ifm_rd_sel_i
	,input  logic                                        fil_rd_sel_i
	,input  logic                                        sub_chunk_start_i
	,input  sparse_ctrl_pkg::seg_addr_t                  last_seg_i

	,output sparse_chunk_pkg::act_t                      ifm_data_o
	,output sparse_chunk_pkg::wgt_t                      fil_data_o
	,output logic                                        data_valid_o
	,output logic                                        sub_chunk_end_o
);

	input_selector u_input_selector (
		 .gated_clk_0_w
		,.rst_i
		,.ifm_wr_valid_i
		,.ifm_wr_sel_i
		,.ifm_wr_count_i
		,.ifm_wr_sparsemap_i
		,.ifm_wr_nonzero_data_i
		,.fil_wr_valid_i
		,.fil_wr_sel_i
		,.fil_wr_count_i
		,.fil_wr_sparsemap_i
		,.fil_wr_nonzero_data_i
		,.ifm_rd_sel_i
		,.fil_rd_sel_i
		,.sub_chunk_start_i
		,.last_seg_i
		,.ifm_data_o
		,.fil_data_o
		,.data_valid_o
		,.sub_chunk_end_o
	);

endmodule

//--- hdl/input_selector.sv
`timescale 1ns/1ns
`include "sparse_sel_cfg.svh"

module input_selector (
	 input  logic                                        gated_clk_0_w
	,input  logic                                        rst_i

	,input  logic                                        ifm_wr_valid_i
	,input  logic                                        ifm_wr_sel_i
	,input  sparse_ctrl_pkg::seg_addr_t                  ifm_wr_count_i
	,input  sparse_chunk_pkg::seg_map_t                  ifm_wr_sparsemap_i
	,input  sparse_chunk_pkg::act_t [`BUS_SIZE-1:0]      ifm_wr_nonzero_data_i

	,input  logic                                        fil_wr_valid_i
	,input  logic                                        fil_wr_sel_i
	,input  sparse_ctrl_pkg::seg_addr_t                  fil_wr_count_i
	,input  sparse_chunk_pkg::seg_map_t                  fil_wr_sparsemap_i
	,input  sparse_chunk_pkg::wgt_t [`BUS_SIZE-1:0]      fil_wr_nonzero_data_i

	,input  logic                                        ifm_rd_sel_i
	,input  logic                                        fil_rd_sel_i
	,input  logic                                        sub_chunk_start_i
	,input  sparse_ctrl_pkg::seg_addr_t                  last_seg_i

	,output sparse_chunk_pkg::act_t                      ifm_data_o
	,output sparse_chunk_pkg::wgt_t                      fil_data_o
	,output logic                                        data_valid_o
	,output logic                                        sub_chunk_end_o
);

	sparse_chunk_pkg::seg_map_t ifm_sparsemap_w;
	sparse_chunk_pkg::seg_map_t fil_sparsemap_w;
	sparse_ctrl_pkg::bit_pos_t  match_pos_w;
	logic                       match_valid_w;
	logic                       pri_enc_last_w;

	sparse_ctrl_pkg::seg_addr_t seg_addr_r;
	sparse_ctrl_pkg::seg_addr_t seg_addr_w;
	logic                       run_r;
	logic                       run_w;
	logic                       seg_load_r;
	logic                       seg_load_w;
	logic                       final_w;

	data_chunk_buffer #(
		.elem_t(sparse_chunk_pkg::act_t)
	) u_chunk_ifm (
		 .gated_clk_0_w
		,.rst_i
		,.wr_valid_i(ifm_wr_valid_i)
		,.wr_sel_i(ifm_wr_sel_i)
		,.wr_count_i(ifm_wr_count_i)
		,.wr_sparsemap_i(ifm_wr_sparsemap_i)
		,.wr_nonzero_data_i(ifm_wr_nonzero_data_i)
		,.rd_sel_i(ifm_rd_sel_i)
		,.rd_seg_addr_i(seg_addr_w)
		,.match_pos_i(match_pos_w)
		,.match_valid_i(match_valid_w)
		,.rd_sparsemap_o(ifm_sparsemap_w)
		,.rd_data_o(ifm_data_o)
	);

	data_chunk_buffer #(
		.elem_t(sparse_chunk_pkg::wgt_t)
	) u_chunk_fil (
		 .gated_clk_0_w
		,.rst_i
		,.wr_valid_i(fil_wr_valid_i)
		,.wr_sel_i(fil_wr_sel_i)
		,.wr_count_i(fil_wr_count_i)
		,.wr_sparsemap_i(fil_wr_sparsemap_i)
		,.wr_nonzero_data_i(fil_wr_nonzero_data_i)
		,.rd_sel_i(fil_rd_sel_i)
		,.rd_seg_addr_i(seg_addr_w)
		,.match_pos_i(match_pos_w)
		,.match_valid_i(match_valid_w)
		,.rd_sparsemap_o(fil_sparsemap_w)
		,.rd_data_o(fil_data_o)
	);

	match_priority_encoder u_match_priority_encoder (
		 .gated_clk_0_w
		,.rst_i
		,.valid_i(run_w)
		,.seg_load_i(seg_load_w)
		,.in1_i(ifm_sparsemap_w)
		,.in2_i(fil_sparsemap_w)
		,.match_pos_o(match_pos_w)
		,.match_valid_o(match_valid_w)
		,.pri_enc_last_o(pri_enc_last_w)
	);

	//////////////////////////////////////////////////////////////////////
	// Run control
	//////////////////////////////////////////////////////////////////////

	assign run_w      = sub_chunk_start_i || run_r;
	assign seg_addr_w = sub_chunk_start_i ? '0 : seg_addr_r;
	assign seg_load_w = sub_chunk_start_i || seg_load_r;
	// Last pair (or empty pass) of the final segment
	assign final_w    = run_w && pri_enc_last_w && (seg_addr_w == last_seg_i);

	always_ff @(posedge gated_clk_0_w) begin
		if (rst_i) begin
			seg_addr_r <= '0;
		end
		else if (pri_enc_last_w) begin
			seg_addr_r <= sparse_ctrl_pkg::seg_addr_t'(seg_addr_w + 1'b1);
		end
		else if (sub_chunk_start_i) begin
			seg_addr_r <= '0;
		end
	end

	always_ff @(posedge gated_clk_0_w) begin
		if (rst_i) begin
			run_r <= 1'b0;
		end
		else if (final_w) begin
			run_r <= 1'b0;
		end
		else if (sub_chunk_start_i) begin
			run_r <= 1'b1;
		end
	end

	always_ff @(posedge gated_clk_0_w) begin
		if (rst_i) begin
			seg_load_r      <= 1'b0;
			data_valid_o    <= 1'b0;
			sub_chunk_end_o <= 1'b0;
		end
		else begin
			seg_load_r      <= pri_enc_last_w;
			data_valid_o    <= match_valid_w;
			sub_chunk_end_o <= final_w;
		end
	end

	a_start_when_idle: assert property (
		@(posedge gated_clk_0_w) disable iff (rst_i)
		sub_chunk_start_i |-> !run_r
	) else $error("sub-chunk start while a run is active");

endmodule

//--- hdl/match_priority_encoder.sv
`timescale 1ns/1ns
`include "sparse_sel_cfg.svh"

module match_priority_encoder (
	 input  logic                          gated_clk_0_w
	,input  logic                          rst_i

	,input  logic                          valid_i
	,input  logic                          seg_load_i
	,input  sparse_chunk_pkg::seg_map_t    in1_i
	,input  sparse_chunk_pkg::seg_map_t    in2_i

	,output sparse_ctrl_pkg::bit_pos_t     match_pos_o
	,output logic                          match_valid_o
	,output logic                          pri_enc_last_o
);

	sparse_chunk_pkg::seg_map_t mask_w;
	sparse_chunk_pkg::seg_map_t rest_w;
	sparse_chunk_pkg::seg_map_t work_r;

	// Fresh AND of both maps on a new segment, leftover bits otherwise
	assign mask_w = seg_load_i ? (in1_i & in2_i) : work_r;

	// Lowest set bit wins
	always_comb begin
		match_pos_o = '0;
		for (int i = `BUS_SIZE - 1; i >= 0; i--) begin
			if (mask_w[i]) begin
				match_pos_o = sparse_ctrl_pkg::bit_pos_t'(i);
			end
		end
	end

	// Drop the lowest set bit
	assign rest_w = mask_w & (mask_w - sparse_chunk_pkg::seg_map_t'(1));

	assign match_valid_o  = valid_i && (mask_w != '0);
	// Empty segment still takes one cycle and reports last
	assign pri_enc_last_o = valid_i && (rest_w == '0);

	always_ff @(posedge gated_clk_0_w) begin
		if (rst_i) begin
			work_r <= '0;
		end
		else if (valid_i) begin
			work_r <= rest_w;
		end
	end

	a_pos_in_mask: assert property (
		@(posedge gated_clk_0_w) disable iff (rst_i)
		match_valid_o |-> mask_w[match_pos_o]
	) else $error("match position %0d not set in mask %b", match_pos_o, mask_w);

endmodule

//--- hdl/data_chunk_buffer.sv
`timescale 1ns/1ns
`include "sparse_sel_cfg.svh"

module data_chunk_buffer #(
	parameter type elem_t = logic [`ELEM_W-1:0]
) (
	 input  logic                              gated_clk_0_w
	,input  logic                              rst_i

	,input  logic                              wr_valid_i
	,input  logic                              wr_sel_i
	,input  sparse_ctrl_pkg::seg_addr_t        wr_count_i
	,input  sparse_chunk_pkg::seg_map_t        wr_sparsemap_i
	,input  elem_t [`BUS_SIZE-1:0]             wr_nonzero_data_i

	,input  logic                              rd_sel_i
	,input  sparse_ctrl_pkg::seg_addr_t        rd_seg_addr_i
	,input  sparse_ctrl_pkg::bit_pos_t         match_pos_i
	,input  logic                              match_valid_i

	,output sparse_chunk_pkg::seg_map_t        rd_sparsemap_o
	,output elem_t                             rd_data_o
);

	// Map and packed nonzero rows, per bank and segment
	sparse_chunk_pkg::seg_map_t map_mem [`BANK_NUM][`SEG_NUM];
	elem_t [`BUS_SIZE-1:0]      data_mem [`BANK_NUM][`SEG_NUM];

	elem_t [`BUS_SIZE-1:0]      rd_row_w;
	sparse_chunk_pkg::seg_map_t below_mask_w;
	sparse_ctrl_pkg::bit_pos_t  elem_idx_w;

	//////////////////////////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge gated_clk_0_w) begin
		if (wr_valid_i) begin
			map_mem[wr_sel_i][wr_count_i]  <= wr_sparsemap_i;
			data_mem[wr_sel_i][wr_count_i] <= wr_nonzero_data_i;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////////////////////////

	assign rd_sparsemap_o = map_mem[rd_sel_i][rd_seg_addr_i];
	assign rd_row_w       = data_mem[rd_sel_i][rd_seg_addr_i];

	// Set bits below the match position give its index in the packed row
	assign below_mask_w = (sparse_chunk_pkg::seg_map_t'(1) << match_pos_i)
		- sparse_chunk_pkg::seg_map_t'(1);
	assign elem_idx_w = sparse_ctrl_pkg::bit_pos_t'($countones(rd_sparsemap_o & below_mask_w));

	always_ff @(posedge gated_clk_0_w) begin
		if (match_valid_i) begin
			rd_data_o <= rd_row_w[elem_idx_w];
		end
	end

	// The bank being scanned must stay stable until the run is over
	a_no_wr_on_rd_bank: assert property (
		@(posedge gated_clk_0_w) disable iff (rst_i)
		match_valid_i |-> !(wr_valid_i && (wr_sel_i == rd_sel_i))
	) else $error("write into bank %0d while it is being read", wr_sel_i);

endmodule

//--- hdl/sparse_ctrl_pkg.sv
`include "sparse_sel_cfg.svh"

package sparse_ctrl_pkg;

	// Segment index inside a chunk, also the write beat count
	typedef logic [$clog2(`SEG_NUM)-1:0] seg_addr_t;

	// Bit position inside one segment
	typedef logic [$clog2(`BUS_SIZE)-1:0] bit_pos_t;

endpackage

//--- hdl/sparse_chunk_pkg.sv
`include "sparse_sel_cfg.svh"

package sparse_chunk_pkg;

	//////////////////////////////////////////////////////////////////////
	// Stored chunk content
	//////////////////////////////////////////////////////////////////////

	// One segment of the sparsemap, bit i set means element i is nonzero
	typedef logic [`BUS_SIZE-1:0] seg_map_t;

	// IFM activation, unsigned
	typedef logic [`ELEM_W-1:0] act_t;

	// Filter weight, two's complement
	typedef logic signed [`ELEM_W-1:0] wgt_t;

endpackage

//--- hdl/sparse_sel_cfg.svh
`ifndef SPARSE_SEL_CFG_SVH
`define SPARSE_SEL_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Bus geometry
//////////////////////////////////////////////////////////////////////

// Bits per sparsemap segment, also bytes per write beat
`define BUS_SIZE 8

// Payload element width
`define ELEM_W 8

//////////////////////////////////////////////////////////////////////
// Chunk geometry
//////////////////////////////////////////////////////////////////////

// Segments per chunk, 32 elements in total
`define SEG_NUM 4

// Double-buffered banks
`define BANK_NUM 2

`endif
